// ==== verilog/sccb_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared SCCB types, 2-wire mode only
// dev_id is 7 bits; the framer appends the r/w bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sccb_pkg;

   // transaction opcode
   typedef enum logic {
      OP_WRITE = 1'b0,  // 3-phase write
      OP_READ  = 1'b1   // 2-phase write, stop, 2-phase read
   } sccb_op_e;

   // one register transaction, 24 bits
   typedef struct packed {
      sccb_op_e   op;
      logic [6:0] dev_id;    // 7-bit slave address
      logic [7:0] reg_addr;  // sub-address
      logic [7:0] wr_data;   // ignored on read
   } sccb_cmd_t;

   // phase kinds handed to the bit engine
   typedef enum logic [1:0] {
      PH_START = 2'd0,  // 1 bit, sio_d falls with sio_c high
      PH_TX    = 2'd1,  // 8 bits out, 9th released (don't care)
      PH_RX    = 2'd2,  // 8 bits in, 9th driven high (NA)
      PH_STOP  = 2'd3   // 2 bits, sio_d rises with sio_c high
   } phase_kind_e;

   // one phase, 10 bits
   typedef struct packed {
      phase_kind_e kind;
      logic [7:0]  tx_byte;  // only for PH_TX
   } sccb_phase_t;

   // camera address (OV2640 write id 0x60 >> 1)
   localparam logic [6:0] SCCB_DEV_CAM = 7'h30;

endpackage

// ==== verilog/sccb_init_seq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot table runs once after reset, host_go ignored until init_done
// one host command at a time, busy until its frame completes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sccb_init_seq (
   input  logic                SCCB_CLK,
   input  logic                RST_N,
   input  sccb_pkg::sccb_cmd_t host_cmd,
   input  logic                host_go,
   input  logic                frame_done,
   input  logic                frame_busy,
   output sccb_pkg::sccb_cmd_t cmd,
   output logic                cmd_go,
   output logic                busy,
   output logic                init_done
);
   import sccb_pkg::*;

   typedef enum logic [1:0] {SEQ_BOOT, SEQ_WAIT, SEQ_IDLE, SEQ_HOST} seq_state_e;

   localparam int BOOT_LEN = 4;  // fixed by the table below

   seq_state_e state;
   logic [1:0] idx;         // boot table entry in flight
   logic       issue;       // cmd_go next cycle
   sccb_cmd_t  issue_cmd;

   // boot register table, all writes to the camera
   function automatic sccb_cmd_t boot_cmd(input logic [1:0] i);
      logic [15:0] rv;  // {reg, data}
      case (i)
         2'd0:    rv = {8'hFF, 8'h01};  // bank select: sensor
         2'd1:    rv = {8'h12, 8'h80};  // COM7 soft reset
         2'd2:    rv = {8'h11, 8'h01};  // CLKRC divider
         default: rv = {8'h15, 8'h02};  // COM10 vsync polarity
      endcase
      boot_cmd = '{op: OP_WRITE, dev_id: SCCB_DEV_CAM, reg_addr: rv[15:8], wr_data: rv[7:0]};
   endfunction

   always_comb begin
      issue     = 1'b0;
      issue_cmd = boot_cmd(idx);
      case (state)
         SEQ_BOOT: issue = !frame_busy;  // first entry right after reset
         SEQ_WAIT: begin
            // chain next entry straight off frame_done
            if (frame_done && idx != 2'(BOOT_LEN - 1)) begin
               issue     = 1'b1;
               issue_cmd = boot_cmd(idx + 2'd1);
            end
         end
         SEQ_IDLE: begin
            if (host_go && !frame_busy) begin
               issue     = 1'b1;
               issue_cmd = host_cmd;
            end
         end
         default: issue = 1'b0;  // SEQ_HOST waits
      endcase
   end

   always_ff @(posedge SCCB_CLK) begin
      if (issue) cmd <= issue_cmd;  // held until the framer latches it
   end

   always_ff @(posedge SCCB_CLK or negedge RST_N) begin
      if (!RST_N) begin
         state  <= SEQ_BOOT;
         idx    <= '0;
         cmd_go <= 1'b0;
      end else begin
         cmd_go <= issue;
         case (state)
            SEQ_BOOT: if (issue) state <= SEQ_WAIT;
            SEQ_WAIT: begin
               if (frame_done) begin
                  if (idx == 2'(BOOT_LEN - 1)) state <= SEQ_IDLE;  // table finished
                  else idx <= idx + 2'd1;
               end
            end
            SEQ_IDLE: if (issue) state <= SEQ_HOST;
            default:  if (frame_done) state <= SEQ_IDLE;
         endcase
      end
   end

   assign busy      = (state == SEQ_HOST);
   assign init_done = (state == SEQ_IDLE) || (state == SEQ_HOST);

endmodule

// ==== verilog/sccb_phase_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cmd_go only while frame_busy is low, cmd sampled on cmd_go
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sccb_phase_ctrl (
   input  logic                  SCCB_CLK,
   input  logic                  RST_N,
   input  sccb_pkg::sccb_cmd_t   cmd,
   input  logic                  cmd_go,
   input  logic                  phase_done,
   input  logic [7:0]            rx_byte,
   output sccb_pkg::sccb_phase_t phase,
   output logic                  phase_go,
   output logic                  frame_busy,
   output logic                  frame_done,
   output logic [7:0]            rd_data,
   output logic                  rd_valid
);
   import sccb_pkg::*;

   // one state per phase of the longest frame (read)
   typedef enum logic [3:0] {
      FR_IDLE, FR_START_A, FR_ID_W, FR_REG, FR_DATA, FR_STOP_A,
      FR_START_B, FR_ID_R, FR_RX, FR_STOP_END
   } fr_state_e;

   fr_state_e state, state_nxt;
   logic      go_nxt;
   sccb_cmd_t cmd_q;     // latched command
   sccb_cmd_t cmd_cur;   // live cmd in idle, latched copy after

   function automatic fr_state_e next_of(input fr_state_e s, input sccb_op_e op);
      case (s)
         FR_START_A: next_of = FR_ID_W;
         FR_ID_W:    next_of = FR_REG;
         FR_REG:     next_of = (op == OP_WRITE) ? FR_DATA : FR_STOP_A;
         FR_DATA:    next_of = FR_STOP_END;
         FR_STOP_A:  next_of = FR_START_B;  // repeated start for read half
         FR_START_B: next_of = FR_ID_R;
         FR_ID_R:    next_of = FR_RX;
         FR_RX:      next_of = FR_STOP_END;
         default:    next_of = FR_IDLE;
      endcase
   endfunction

   function automatic sccb_phase_t phase_of(input fr_state_e s, input sccb_cmd_t c);
      phase_kind_e k;
      logic [7:0]  b;
      b = 8'h00;
      case (s)
         FR_START_A, FR_START_B: k = PH_START;
         FR_ID_W: begin
            k = PH_TX;
            b = {c.dev_id, 1'b0};  // write id
         end
         FR_ID_R: begin
            k = PH_TX;
            b = {c.dev_id, 1'b1};  // read id
         end
         FR_REG: begin
            k = PH_TX;
            b = c.reg_addr;
         end
         FR_DATA: begin
            k = PH_TX;
            b = c.wr_data;
         end
         FR_RX:   k = PH_RX;
         default: k = PH_STOP;
      endcase
      phase_of = '{kind: k, tx_byte: b};
   endfunction

   assign cmd_cur = (state == FR_IDLE) ? cmd : cmd_q;

   always_comb begin
      state_nxt = state;
      go_nxt    = 1'b0;
      if (state == FR_IDLE) begin
         if (cmd_go) begin
            state_nxt = FR_START_A;
            go_nxt    = 1'b1;
         end
      end else if (phase_done) begin
         state_nxt = next_of(state, cmd_q.op);
         go_nxt    = (state_nxt != FR_IDLE);  // no phase after the final stop
      end
   end

   // payload regs
   always_ff @(posedge SCCB_CLK) begin
      if (state == FR_IDLE && cmd_go) cmd_q <= cmd;
      if (go_nxt) phase <= phase_of(state_nxt, cmd_cur);
      if (phase_done && state == FR_RX) rd_data <= rx_byte;  // held until next read
   end

   always_ff @(posedge SCCB_CLK or negedge RST_N) begin
      if (!RST_N) begin
         state      <= FR_IDLE;
         phase_go   <= 1'b0;
         frame_done <= 1'b0;
         rd_valid   <= 1'b0;
      end else begin
         state      <= state_nxt;
         phase_go   <= go_nxt;
         frame_done <= phase_done && (state == FR_STOP_END);
         rd_valid   <= phase_done && (state == FR_RX);
      end
   end

   assign frame_busy = (state != FR_IDLE);

endmodule

// ==== verilog/sccb_bit_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no clock stretching; sio_d_i used unsynchronized, CLK_DIV >= 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sccb_bit_engine #(
   parameter int CLK_DIV = 125  // SCCB_CLK cycles per quarter bit
) (
   input  logic                  SCCB_CLK,
   input  logic                  RST_N,
   input  sccb_pkg::sccb_phase_t phase,
   input  logic                  phase_go,
   output logic                  phase_done,
   output logic [7:0]            rx_byte,
   output logic                  sio_c,
   output logic                  sio_d_o,
   output logic                  sio_d_oe,
   input  logic                  sio_d_i
);
   import sccb_pkg::*;

   localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

   logic [DIV_W-1:0] div_cnt;
   logic             tick;       // last cycle of a quarter
   logic             active;
   phase_kind_e      kind;
   logic [3:0]       bit_cnt;
   logic [3:0]       last_bit;
   logic [1:0]       qtr;        // 0,1 clock low  2,3 clock high (data bits)
   logic [7:0]       shreg;      // tx bits out msb first
   logic             c_nxt, d_o_nxt, d_oe_nxt;

   assign tick = active && (div_cnt == DIV_W'(CLK_DIV - 1));

   always_comb begin
      case (kind)
         PH_START: last_bit = 4'd0;
         PH_STOP:  last_bit = 4'd1;
         default:  last_bit = 4'd8;  // 8 data + 9th bit
      endcase
   end

   // q0 of a clocked bit holds sio_d so it only moves after sio_c fell
   always_comb begin
      c_nxt    = 1'b1;
      d_o_nxt  = sio_d_o;
      d_oe_nxt = sio_d_oe;
      if (!active) begin
         if (kind != PH_START) begin  // after a start sio_d stays low until the next bit
            d_o_nxt  = 1'b1;  // idle clock high and data released
            d_oe_nxt = 1'b0;
         end
      end else if (kind == PH_START) begin
         d_oe_nxt = 1'b1;
         d_o_nxt  = ~qtr[1];  // falls halfway while clock stays high
      end else if (kind == PH_STOP && bit_cnt == 4'd1) begin
         d_oe_nxt = 1'b1;
         d_o_nxt  = qtr[1];   // rises halfway while clock stays high
      end else begin
         c_nxt = qtr[1];
         if (qtr != 2'd0) begin
            case (kind)
               PH_TX: begin
                  d_oe_nxt = (bit_cnt != 4'd8);  // release for don't care
                  d_o_nxt  = (bit_cnt == 4'd8) ? 1'b1 : shreg[7];
               end
               PH_RX: begin
                  d_oe_nxt = (bit_cnt == 4'd8);  // master drives NA
                  d_o_nxt  = 1'b1;
               end
               default: begin
                  d_oe_nxt = 1'b1;  // stop bit 0 pulls data low
                  d_o_nxt  = 1'b0;
               end
            endcase
         end
      end
   end

   always_ff @(posedge SCCB_CLK or negedge RST_N) begin
      if (!RST_N) begin
         active     <= 1'b0;
         kind       <= PH_START;
         div_cnt    <= '0;
         bit_cnt    <= '0;
         qtr        <= '0;
         phase_done <= 1'b0;
         sio_c      <= 1'b1;
         sio_d_o    <= 1'b1;
         sio_d_oe   <= 1'b0;
      end else begin
         phase_done <= 1'b0;
         sio_c      <= c_nxt;     // all pins one cycle behind the counters
         sio_d_o    <= d_o_nxt;
         sio_d_oe   <= d_oe_nxt;
         if (!active && phase_go) begin
            active  <= 1'b1;
            kind    <= phase.kind;
            div_cnt <= '0;
            bit_cnt <= '0;
            qtr     <= '0;
         end else if (active) begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
               qtr <= qtr + 2'd1;
               if (qtr == 2'd3) begin
                  if (bit_cnt == last_bit) begin
                     active     <= 1'b0;
                     phase_done <= 1'b1;  // cycle after last quarter
                  end else begin
                     bit_cnt <= bit_cnt + 4'd1;
                  end
               end
            end
         end
      end
   end

   // shift and sample paths
   always_ff @(posedge SCCB_CLK) begin
      if (!active && phase_go) begin
         shreg <= phase.tx_byte;
      end else if (tick && qtr == 2'd3 && kind == PH_TX) begin
         shreg <= {shreg[6:0], 1'b0};  // next bit at end of this one
      end
      if (tick && qtr == 2'd2 && kind == PH_RX && bit_cnt < 4'd8) begin
         rx_byte <= {rx_byte[6:0], sio_d_i};  // sample mid clock-high
      end
   end

endmodule

// ==== verilog/sccb_master.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sio_d split in o/oe/i, bus resolved outside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sccb_master #(
   parameter int CLK_DIV = 125  // quarter bit in SCCB_CLK cycles
) (
   input  logic                SCCB_CLK,
   input  logic                RST_N,
   input  sccb_pkg::sccb_cmd_t host_cmd,
   input  logic                host_go,
   output logic                busy,
   output logic                init_done,
   output logic [7:0]          rd_data,
   output logic                rd_valid,
   output logic                sio_c,
   output logic                sio_d_o,
   output logic                sio_d_oe,
   input  logic                sio_d_i
);
   import sccb_pkg::*;

   sccb_cmd_t   cmd;          // command stage -> framer
   logic        cmd_go;
   logic        frame_done;
   logic        frame_busy;
   sccb_phase_t phase;        // framer -> bit engine
   logic        phase_go;
   logic        phase_done;
   logic [7:0]  rx_byte;

   sccb_init_seq sccb_init_seq_i (
      .SCCB_CLK   (SCCB_CLK),
      .RST_N      (RST_N),
      .host_cmd   (host_cmd),
      .host_go    (host_go),
      .frame_done (frame_done),
      .frame_busy (frame_busy),
      .cmd        (cmd),
      .cmd_go     (cmd_go),
      .busy       (busy),
      .init_done  (init_done)
   );

   sccb_phase_ctrl sccb_phase_ctrl_i (
      .SCCB_CLK   (SCCB_CLK),
      .RST_N      (RST_N),
      .cmd        (cmd),
      .cmd_go     (cmd_go),
      .phase_done (phase_done),
      .rx_byte    (rx_byte),
      .phase      (phase),
      .phase_go   (phase_go),
      .frame_busy (frame_busy),
      .frame_done (frame_done),
      .rd_data    (rd_data),
      .rd_valid   (rd_valid)
   );

   sccb_bit_engine #(
      .CLK_DIV (CLK_DIV)
   ) sccb_bit_engine_i (
      .SCCB_CLK   (SCCB_CLK),
      .RST_N      (RST_N),
      .phase      (phase),
      .phase_go   (phase_go),
      .phase_done (phase_done),
      .rx_byte    (rx_byte),
      .sio_c      (sio_c),
      .sio_d_o    (sio_d_o),
      .sio_d_oe   (sio_d_oe),
      .sio_d_i    (sio_d_i)
   );

endmodule

// ==== sim/sccb_cam_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// oversamples the bus on SCCB_CLK and never drives an ACK
// one read byte per frame and register pointer kept across stops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sccb_cam_model (
   input  logic SCCB_CLK,  // sampling clock much faster than sio_c
   input  logic RST_N,
   input  logic sio_c,
   input  logic sio_d,     // resolved bus
   output logic d_o,
   output logic d_oe
);
   timeunit 1ns;
   timeprecision 100ps;
   import sccb_pkg::*;

   logic [7:0] regs [256];
   logic       c_q, d_q;        // previous bus levels
   logic       in_frame;
   logic       addressed, is_read, rd_phase;
   logic [3:0] bit_cnt;         // 0..8 within a phase
   logic [1:0] byte_idx;        // phases done in this frame
   logic [7:0] shin, shout, ptr;

   always @(posedge SCCB_CLK or negedge RST_N) begin
      if (!RST_N) begin
         for (int i = 0; i < 256; i++) regs[i] <= 8'(i) ^ 8'hA5;
         c_q       <= 1'b1;
         d_q       <= 1'b1;
         in_frame  <= 1'b0;
         addressed <= 1'b0;
         is_read   <= 1'b0;
         rd_phase  <= 1'b0;
         bit_cnt   <= '0;
         byte_idx  <= '0;
         shin      <= '0;
         shout     <= '0;
         ptr       <= '0;
         d_o       <= 1'b1;
         d_oe      <= 1'b0;
      end else begin
         c_q <= sio_c;
         d_q <= sio_d;
         if (c_q && sio_c && d_q && !sio_d) begin  // start
            in_frame <= 1'b1;
            bit_cnt  <= '0;
            byte_idx <= '0;
            rd_phase <= 1'b0;
            d_oe     <= 1'b0;
         end else if (c_q && sio_c && !d_q && sio_d) begin  // stop
            in_frame <= 1'b0;
            rd_phase <= 1'b0;
            d_oe     <= 1'b0;
         end else if (in_frame && !c_q && sio_c) begin  // sio_c rising edge samples
            if (bit_cnt < 4'd8) begin
               shin    <= {shin[6:0], sio_d};
               bit_cnt <= bit_cnt + 4'd1;
               if (rd_phase) shout <= {shout[6:0], 1'b0};
            end else begin
               // 9th bit ends the phase
               bit_cnt <= '0;
               if (byte_idx != 2'd3) byte_idx <= byte_idx + 2'd1;
               case (byte_idx)
                  2'd0: begin
                     addressed <= (shin[7:1] == SCCB_DEV_CAM);
                     is_read   <= shin[0];
                     if (shin[7:1] == SCCB_DEV_CAM && shin[0]) begin
                        rd_phase <= 1'b1;
                        shout    <= regs[ptr];
                     end
                  end
                  2'd1: begin
                     if (is_read) rd_phase <= 1'b0;  // NA ends the read
                     else if (addressed) ptr <= shin;
                  end
                  2'd2: if (addressed && !is_read) regs[ptr] <= shin;
                  default: ;  // stop bit clocks land here
               endcase
            end
         end else if (in_frame && c_q && !sio_c) begin  // sio_c falling edge drives
            d_oe <= rd_phase && (bit_cnt < 4'd8);
            d_o  <= rd_phase ? shout[7] : 1'b1;
         end
      end
   end

endmodule

// ==== sim/sccb_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLK_DIV 4; checks are immediate assertions, build with --assert
// model registers read hierarchically through cam_i.regs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sccb_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import sccb_pkg::*;

   localparam int TXN_TMO  = 3000;   // cycles for one transaction
   localparam int BOOT_TMO = 12000;  // cycles for the whole boot table

   logic        SCCB_CLK;
   logic        RST_N;
   sccb_cmd_t   host_cmd;
   logic        host_go;
   logic        busy, init_done, rd_valid;
   logic [7:0]  rd_data;
   logic        sio_c, sio_d_o, sio_d_oe;
   logic        sio_d;             // resolved line
   logic        cam_d_o, cam_d_oe;
   string       cur_test;
   int          errs, errs_at_start, n_pass, n_fail;
   logic [31:0] rng;
   logic        touched [256];     // written at least once
   logic [7:0]  snap [256];
   logic        abort;

   assign sio_d = (cam_d_oe && !cam_d_o) ? 1'b0 : (sio_d_oe ? sio_d_o : 1'b1);  // low wins

   sccb_master #(.CLK_DIV(4)) sccb_master_i (
      .SCCB_CLK (SCCB_CLK), .RST_N (RST_N), .host_cmd (host_cmd), .host_go (host_go),
      .busy (busy), .init_done (init_done), .rd_data (rd_data), .rd_valid (rd_valid),
      .sio_c (sio_c), .sio_d_o (sio_d_o), .sio_d_oe (sio_d_oe), .sio_d_i (sio_d)
   );

   sccb_cam_model cam_i (
      .SCCB_CLK (SCCB_CLK), .RST_N (RST_N), .sio_c (sio_c), .sio_d (sio_d),
      .d_o (cam_d_o), .d_oe (cam_d_oe)
   );

   initial begin
      SCCB_CLK = 1'b0;
      forever #2 SCCB_CLK = ~SCCB_CLK;
   end

   // ends the run after a timeout
   initial begin
      wait (abort === 1'b1);
      $display("Test FAILED");
      $finish;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check(input string what, input logic [7:0] exp, input logic [7:0] act);
      assert (act === exp) else begin
         $display("ERR %s %s: expected %02h, actual %02h", cur_test, what, exp, act);
         errs++;
      end
   endtask

   task automatic check_reg(input logic [7:0] a, input logic [7:0] exp);
      check($sformatf("reg %02h", a), exp, cam_i.regs[a]);
   endtask

   task automatic check_idle();
      check("sio_c idle", 8'd1, {7'd0, sio_c});
      check("sio_d_oe idle", 8'd0, {7'd0, sio_d_oe});
   endtask

   task automatic abort_run(input string why);
      $display("%s: %s", cur_test, why);
      abort = 1'b1;
      forever @(negedge SCCB_CLK);  // parked, the abort process finishes
   endtask

   task automatic start_test(input string name);
      cur_test      = name;
      errs_at_start = errs;
   endtask

   task automatic close_test();
      if (errs == errs_at_start) begin
         n_pass++;
         $display("[%s] pass", cur_test);
      end else begin
         n_fail++;
         $display("[%s] fail, %0d errors", cur_test, errs - errs_at_start);
      end
   endtask

   task automatic wait_init();
      int n;
      n = 0;
      while (!init_done && n < BOOT_TMO) begin
         @(negedge SCCB_CLK);
         n++;
      end
      if (!init_done) abort_run("init_done never rose");
   endtask

   // called on a falling edge with busy low
   task automatic issue_cmd(input sccb_cmd_t c);
      host_cmd = c;
      host_go  = 1'b1;
      @(negedge SCCB_CLK);
      host_go  = 1'b0;
      assert (busy) else begin
         $display("%s: host command was not accepted", cur_test);
         errs++;
      end
   endtask

   // waits for busy to fall, collects rd_valid pulses on the way
   task automatic finish_cmd(output logic [7:0] rd, output int pulses);
      int n;
      n      = 0;
      pulses = 0;
      rd     = 8'h00;
      while (busy && n < TXN_TMO) begin
         @(negedge SCCB_CLK);
         if (rd_valid) begin
            pulses++;
            rd = rd_data;
         end
         n++;
      end
      if (busy) abort_run("busy stayed high, transaction never finished");
      check_idle();
   endtask

   task automatic write_reg(input logic [6:0] dev, input logic [7:0] a, input logic [7:0] d);
      logic [7:0] rd;
      int         pulses;
      issue_cmd('{op: OP_WRITE, dev_id: dev, reg_addr: a, wr_data: d});
      finish_cmd(rd, pulses);
      check("rd_valid pulses on write", 8'd0, 8'(pulses));
   endtask

   task automatic read_reg(input logic [7:0] a, output logic [7:0] rd, output int pulses);
      issue_cmd('{op: OP_READ, dev_id: SCCB_DEV_CAM, reg_addr: a, wr_data: 8'h00});
      finish_cmd(rd, pulses);
   endtask

   initial begin
      logic [7:0] a, d, d2, rd;
      int         pulses;
      abort    = 1'b0;
      errs     = 0;
      n_pass   = 0;
      n_fail   = 0;
      rng      = 32'd43;
      RST_N    = 1'b0;
      host_go  = 1'b0;
      host_cmd = '0;
      for (int i = 0; i < 256; i++) touched[i] = 1'b0;

      start_test("idle_bus");
      repeat (4) @(negedge SCCB_CLK);
      check_idle();  // still in reset
      RST_N = 1'b1;
      close_test();

      start_test("boot_table");
      wait_init();
      check_idle();
      check_reg(8'hFF, 8'h01);
      check_reg(8'h12, 8'h80);
      check_reg(8'h11, 8'h01);
      check_reg(8'h15, 8'h02);
      check_reg(8'h13, 8'h13 ^ 8'hA5);  // neighbor keeps reset value
      touched[8'hFF] = 1'b1;
      touched[8'h12] = 1'b1;
      touched[8'h11] = 1'b1;
      touched[8'h15] = 1'b1;
      close_test();

      start_test("write_read");
      for (int k = 0; k < 8; k++) begin
         rng = xorshift(rng);
         a   = rng[7:0];
         d   = rng[15:8];
         write_reg(SCCB_DEV_CAM, a, d);
         check_reg(a, d);
         read_reg(a, rd, pulses);
         check("read data", d, rd);
         check("rd_valid pulses", 8'd1, 8'(pulses));
         touched[a] = 1'b1;
      end
      close_test();

      start_test("untouched_reg");
      a = 8'h40;
      while (touched[a]) a = a + 8'd1;
      read_reg(a, rd, pulses);
      check("read data", a ^ 8'hA5, rd);
      check("rd_valid pulses", 8'd1, 8'(pulses));
      close_test();

      start_test("busy_rule");
      rng = xorshift(rng);
      a   = rng[7:0];
      d   = rng[15:8];
      d2  = ~d;
      issue_cmd('{op: OP_WRITE, dev_id: SCCB_DEV_CAM, reg_addr: a, wr_data: d});
      repeat (10) @(negedge SCCB_CLK);
      assert (busy) else begin
         $display("%s: busy fell before the second host_go", cur_test);
         errs++;
      end
      host_cmd = '{op: OP_WRITE, dev_id: SCCB_DEV_CAM, reg_addr: a, wr_data: d2};
      host_go  = 1'b1;  // must be dropped
      @(negedge SCCB_CLK);
      host_go  = 1'b0;
      finish_cmd(rd, pulses);
      repeat (4) @(negedge SCCB_CLK);
      check("busy after first command", 8'd0, {7'd0, busy});
      check_reg(a, d);
      read_reg(a, rd, pulses);
      check("read data", d, rd);
      touched[a] = 1'b1;
      close_test();

      start_test("foreign_dev");
      rng = xorshift(rng);
      a   = rng[7:0];
      d   = rng[15:8];
      for (int i = 0; i < 256; i++) snap[i] = cam_i.regs[i];
      write_reg(7'h21, a, d);
      for (int i = 0; i < 256; i++) check_reg(8'(i), snap[i]);
      close_test();

      $display("tests %0d, passed %0d, failed %0d, check errors %0d",
               n_pass + n_fail, n_pass, n_fail, errs);
      if (n_fail == 0 && errs == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
verilog/sccb_pkg.sv
verilog/sccb_init_seq.sv
verilog/sccb_phase_ctrl.sv
verilog/sccb_bit_engine.sv
verilog/sccb_master.sv
sim/sccb_cam_model.sv
sim/sccb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the SCCB testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f verilog.f --top-module sccb_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vsccb_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
   exit 0
fi
exit 1
